/* include/time_cfg.svh */
// Address map and readback timing for the time subsystem.
// Include wherever settings or readback addresses are decoded or checked.
`ifndef TIME_CFG_SVH
`define TIME_CFG_SVH

// Settings bus registers. Time-high is at the base.
`define TIME_BASE 8'h20
// Time-low register, written before or after the high word.
`define TIME_LO_ADDR (`TIME_BASE + 8'd1)
// Control register with set_pps and set_now.
`define TIME_CTRL_ADDR (`TIME_BASE + 8'd2)

// Readback word addresses: now_hi, now_lo_latched, pps_hi, pps_lo_latched.
`define RB_BASE 8'h10
// Number of readback words decoded above the base.
`define RB_WORDS 4

// Cycles from read strobe to rb_valid.
`define RB_LATENCY 1

`endif

/* rtl/time_pkg.sv */
// Shared types for the VITA time subsystem.
// Buses, control bits and state encodings are referenced as time_pkg::name.
package time_pkg;

   // Single-cycle settings write strobe from the host.
   typedef struct packed {
      logic        stb;  // Write strobe, one cycle.
      logic [7:0]  addr; // Register address.
      logic [31:0] data; // Write data.
   } set_bus_t;

   // Readback request, one read per strobe.
   typedef struct packed {
      logic       stb;  // Read strobe.
      logic [7:0] addr; // Readback address.
   } rb_req_t;

   // Readback response, fixed latency after the strobe.
   typedef struct packed {
      logic        valid; // Response strobe.
      logic [31:0] data;  // Addressed word.
   } rb_resp_t;

   // Control register bits, set_pps in bit 1.
   typedef struct packed {
      logic set_pps; // Load time at next PPS edge.
      logic set_now; // Load time right away.
   } time_ctrl_t;

   // Trigger FSM in the timekeeper.
   typedef enum logic {
      TRIG_IDLE  = 1'b0,
      TRIG_ARMED = 1'b1
   } trig_state_e;

   // Readback words, in address order above the readback base.
   typedef enum logic [1:0] {
      RB_NOW_HI     = 2'd0,
      RB_NOW_LO_LAT = 2'd1,
      RB_PPS_HI     = 2'd2,
      RB_PPS_LO_LAT = 2'd3
   } rb_sel_e;

endpackage

/* rtl/setting_reg.sv */
// One settings register on the strobe bus.
// Holds the low width bits of the last matching write and pulses changed after it.
`timescale 1ns/1ns

module setting_reg #(
   parameter logic [7:0] addr_match = 8'd0, // Address this register answers to.
   parameter int         width      = 32    // Stored bits, taken from the data LSBs.
) (
   input  logic                 clk,
   input  logic                 reset,
   input  time_pkg::set_bus_t   set_bus,
   output logic [width-1:0]     value,
   output logic                 changed
);

   logic hit; // Write aimed at this register.

   assign hit = set_bus.stb && (set_bus.addr == addr_match);

   always_ff @(posedge clk) begin
      if (reset) begin
         value   <= '0;
         changed <= 1'b0;
      end else begin
         changed <= hit; // One-cycle pulse per write.
         if (hit) begin
            value <= set_bus.data[width-1:0];
         end
      end
   end

endmodule

/* rtl/timekeeper.sv */
// VITA time counter with PPS sync, edge detect, trigger arming and last-PPS capture.
// Loads time_next immediately or on the next PPS edge after a control write.
`timescale 1ns/1ns

module timekeeper (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 pps,               // Asynchronous PPS input.
   input  logic [63:0]          time_next,         // Time to load at the next event.
   input  time_pkg::time_ctrl_t ctrl,
   input  logic                 ctrl_changed,      // Pulse after a control write.
   output logic [63:0]          vita_time,
   output logic [63:0]          vita_time_lastpps
);

   logic [1:0]            pps_sync;       // Two-flop synchronizer, bit 1 is stable.
   logic                  pps_hist;       // Previous synchronized level.
   logic                  pps_edge;       // Registered rising edge, one cycle.
   logic                  ctrl_changed_d; // Control write, delayed to arm.
   logic                  time_event;     // Load time_next this cycle.
   time_pkg::trig_state_e trig_state;

   // Synchronize pps and register the rising edge.
   always_ff @(posedge clk) begin
      if (reset) begin
         pps_sync <= 2'b00;
         pps_hist <= 1'b0;
         pps_edge <= 1'b0;
      end else begin
         pps_sync <= {pps_sync[0], pps};
         pps_hist <= pps_sync[1];
         pps_edge <= pps_sync[1] & ~pps_hist; // High in the cycle after p+2.
      end
   end

   // Hold off arming one cycle so time_next and ctrl are settled.
   always_ff @(posedge clk) begin
      if (reset) begin
         ctrl_changed_d <= 1'b0;
      end else begin
         ctrl_changed_d <= ctrl_changed;
      end
   end

   // Fire once armed, either right away or on the PPS edge.
   assign time_event = (trig_state == time_pkg::TRIG_ARMED) &&
                       (ctrl.set_now || (ctrl.set_pps && pps_edge));

   // Trigger FSM. An event always drops back to idle.
   always_ff @(posedge clk) begin
      if (reset) begin
         trig_state <= time_pkg::TRIG_IDLE;
      end else begin
         case (trig_state)
            time_pkg::TRIG_IDLE: begin
               if (ctrl_changed_d) begin
                  trig_state <= time_pkg::TRIG_ARMED;
               end
            end
            time_pkg::TRIG_ARMED: begin
               if (time_event) begin
                  trig_state <= time_pkg::TRIG_IDLE;
               end
            end
            default: trig_state <= time_pkg::TRIG_IDLE;
         endcase
      end
   end

   // Free-running counter, reloaded on an event.
   always_ff @(posedge clk) begin
      if (reset) begin
         vita_time <= 64'd0;
      end else if (time_event) begin
         vita_time <= time_next;
      end else begin
         vita_time <= vita_time + 64'd1;
      end
   end

   // Record the time that takes effect at the PPS edge.
   always_ff @(posedge clk) begin
      if (reset) begin
         vita_time_lastpps <= 64'd0;
      end else if (pps_edge) begin
         if (time_event) begin
            vita_time_lastpps <= time_next; // Loaded time wins.
         end else begin
            vita_time_lastpps <= vita_time + 64'd1; // Same as the new vita_time.
         end
      end
   end

endmodule

/* rtl/time_readback.sv */
// Readback port for the VITA time words.
// A high-word read snapshots all 64 bits so the following low-word read is tear-free.
`timescale 1ns/1ns
`include "time_cfg.svh"

module time_readback (
   input  logic               clk,
   input  logic               reset,
   input  time_pkg::rb_req_t  rb_req,
   input  logic [63:0]        vita_time,
   input  logic [63:0]        vita_time_lastpps,
   output time_pkg::rb_resp_t rb_resp
);

   logic [7:0]        rb_offset;  // Address relative to the readback base.
   logic              addr_hit;   // Address falls in the readback window.
   time_pkg::rb_sel_e rb_sel;
   logic [63:0]       shadow_now; // Snapshot taken on now_hi.
   logic [63:0]       shadow_pps; // Snapshot taken on pps_hi.
   logic [31:0]       read_word;  // Word selected this cycle.
   logic              resp_valid;
   logic [31:0]       resp_data;

   // Address decode.
   assign rb_offset = rb_req.addr - `RB_BASE;
   assign addr_hit  = (rb_offset < 8'(`RB_WORDS));
   assign rb_sel    = time_pkg::rb_sel_e'(rb_offset[1:0]);

   always_comb begin
      read_word = 32'd0; // Unknown address reads as zero.
      if (addr_hit) begin
         case (rb_sel)
            time_pkg::RB_NOW_HI:     read_word = vita_time[63:32];
            time_pkg::RB_NOW_LO_LAT: read_word = shadow_now[31:0];
            time_pkg::RB_PPS_HI:     read_word = vita_time_lastpps[63:32];
            time_pkg::RB_PPS_LO_LAT: read_word = shadow_pps[31:0];
            default:                 read_word = 32'd0;
         endcase
      end
   end

   // Snapshots on high-word reads.
   always_ff @(posedge clk) begin
      if (rb_req.stb && addr_hit) begin
         if (rb_sel == time_pkg::RB_NOW_HI) begin
            shadow_now <= vita_time;
         end
         if (rb_sel == time_pkg::RB_PPS_HI) begin
            shadow_pps <= vita_time_lastpps;
         end
      end
   end

   // One-cycle response.
   always_ff @(posedge clk) begin
      if (reset) begin
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= rb_req.stb; // Every strobe gets an answer.
      end
   end

   always_ff @(posedge clk) begin
      if (rb_req.stb) begin
         resp_data <= read_word;
      end
   end

   assign rb_resp = '{valid: resp_valid, data: resp_data};

endmodule

/* rtl/time_subsys_top.sv */
// Top of the time subsystem: settings registers, timekeeper and readback port.
// Host writes time and control on set_bus and reads time words on rb_req.
`timescale 1ns/1ns
`include "time_cfg.svh"

module time_subsys_top (
   input  logic               clk,
   input  logic               reset,
   input  logic               pps,
   input  time_pkg::set_bus_t set_bus,
   input  time_pkg::rb_req_t  rb_req,
   output time_pkg::rb_resp_t rb_resp,
   output logic [63:0]        vita_time,
   output logic [63:0]        vita_time_lastpps
);

   logic [63:0]          time_next;    // Time to load, hi and lo registers.
   time_pkg::time_ctrl_t ctrl;
   logic                 ctrl_changed; // Arms the trigger.

   setting_reg #(.addr_match(`TIME_BASE), .width(32)) sr_time_hi (
      .clk(clk), .reset(reset), .set_bus(set_bus),
      .value(time_next[63:32]), .changed()
   );

   setting_reg #(.addr_match(`TIME_LO_ADDR), .width(32)) sr_time_lo (
      .clk(clk), .reset(reset), .set_bus(set_bus),
      .value(time_next[31:0]), .changed()
   );

   setting_reg #(.addr_match(`TIME_CTRL_ADDR), .width(2)) sr_ctrl (
      .clk(clk), .reset(reset), .set_bus(set_bus),
      .value(ctrl), .changed(ctrl_changed)
   );

   timekeeper timekeeper_i (
      .clk(clk), .reset(reset), .pps(pps),
      .time_next(time_next), .ctrl(ctrl), .ctrl_changed(ctrl_changed),
      .vita_time(vita_time), .vita_time_lastpps(vita_time_lastpps)
   );

   time_readback time_readback_i (
      .clk(clk), .reset(reset), .rb_req(rb_req),
      .vita_time(vita_time), .vita_time_lastpps(vita_time_lastpps),
      .rb_resp(rb_resp)
   );

endmodule

/* tests/time_subsys_properties.sv */
// Concurrent checks on the timekeeper trigger, counter and last-PPS register.
// Bound into every timekeeper instance at the end of this file.
`timescale 1ns/1ns

module time_subsys_properties (
   input logic                  clk,
   input logic                  reset,
   input time_pkg::trig_state_e trig_state,
   input logic                  time_event,
   input logic                  pps_edge,
   input logic [63:0]           vita_time,
   input logic [63:0]           vita_time_lastpps
);

   // An event always drops the trigger back to idle.
   trig_idle_after_event: assert property (
      @(posedge clk) disable iff (reset)
      time_event |=> (trig_state == time_pkg::TRIG_IDLE)
   ) else $error("trigger still armed after a time event");

   // Counter steps by one unless loaded.
   count_by_one: assert property (
      @(posedge clk) disable iff (reset)
      !time_event |=> (vita_time == $past(vita_time) + 64'd1)
   ) else $error("vita_time did not advance by one");

   // Last-PPS only moves right after a detected edge.
   lastpps_on_edge: assert property (
      @(posedge clk) disable iff (reset)
      (vita_time_lastpps != $past(vita_time_lastpps)) |-> $past(pps_edge)
   ) else $error("vita_time_lastpps changed without a PPS edge");

endmodule

bind timekeeper time_subsys_properties props_i (
   .clk(clk),
   .reset(reset),
   .trig_state(trig_state),
   .time_event(time_event),
   .pps_edge(pps_edge),
   .vita_time(vita_time),
   .vita_time_lastpps(vita_time_lastpps)
);

/* tests/time_subsys_tb.sv */
// Testbench for the time subsystem top level.
// Runs the operations in tests/time_patterns.txt against a cycle model of the time base.
`timescale 1ns/1ns
`include "time_cfg.svh"

module time_subsys_tb;

   localparam int RB_TIMEOUT = 16; // Cycles allowed for a readback answer.

   logic               clk;
   logic               reset;
   logic               pps;
   time_pkg::set_bus_t set_bus;
   time_pkg::rb_req_t  rb_req;
   time_pkg::rb_resp_t rb_resp;
   logic [63:0]        vita_time;
   logic [63:0]        vita_time_lastpps;

   // Cycle model of the time base.
   logic [63:0] m_time;       // Expected vita_time.
   logic [63:0] m_lastpps;    // Expected vita_time_lastpps.
   logic [63:0] m_next;       // Time held in the hi and lo registers.
   logic [1:0]  m_ctrl;       // Bit 1 set_pps, bit 0 set_now.
   logic        m_armed;      // Trigger armed.
   int          arm_cnt;      // Edges left until the trigger arms.
   int          pps_cnt;      // Edges left until the PPS edge takes effect.
   logic        m_pps_prev;   // Last sampled pps level.
   logic [63:0] m_shadow_now; // Snapshot from the last now_hi read.
   logic [63:0] m_shadow_pps; // Snapshot from the last pps_hi read.
   logic [31:0] rb_expect;    // Expected data of the last read.
   logic [7:0]  stb_hist;     // Read strobes at recent edges, newest in bit 0.

   logic [31:0] rng_state;

   time_subsys_top dut_i (
      .clk(clk), .reset(reset), .pps(pps),
      .set_bus(set_bus), .rb_req(rb_req), .rb_resp(rb_resp),
      .vita_time(vita_time), .vita_time_lastpps(vita_time_lastpps)
   );

   always begin
      #4 clk = ~clk; // 8 ns period.
   end

   // 32-bit xorshift step.
   function automatic logic [31:0] xorshift_next(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         $display("mismatch at %0t ns: %s expected %h actual %h",
                  $time, name, expected, actual);
         $display("Regression failed");
         $fatal(1);
      end
   endtask

   // One clock: advance the model at the rising edge, check at the falling edge.
   task automatic step();
      logic        event_now;
      logic        pps_due;
      logic [63:0] old_time;
      logic [63:0] old_lastpps;
      logic [7:0]  offset;
      @(posedge clk);
      old_time    = m_time;
      old_lastpps = m_lastpps;
      pps_due     = (pps_cnt == 1); // Edge p+3 of a detected pulse.
      event_now   = m_armed && (m_ctrl[0] || (m_ctrl[1] && pps_due));
      if (event_now) begin
         m_time  = m_next;
         m_armed = 1'b0;
      end else begin
         m_time = old_time + 64'd1;
      end
      if (pps_due) begin
         m_lastpps = event_now ? m_next : old_time + 64'd1;
      end
      if (pps_cnt != 0) pps_cnt--;
      if (pps && !m_pps_prev) pps_cnt = 3; // Rising pps sampled here.
      m_pps_prev = pps;
      if (arm_cnt != 0) begin
         arm_cnt--;
         if (arm_cnt == 0) m_armed = 1'b1; // Armed at edge k+2.
      end
      if (set_bus.stb) begin
         if (set_bus.addr == `TIME_BASE) m_next[63:32] = set_bus.data;
         if (set_bus.addr == `TIME_LO_ADDR) m_next[31:0] = set_bus.data;
         if (set_bus.addr == `TIME_CTRL_ADDR) begin
            m_ctrl  = set_bus.data[1:0];
            arm_cnt = 2;
         end
      end
      stb_hist = {stb_hist[6:0], rb_req.stb}; // Strobe sampled at this edge.
      if (rb_req.stb) begin
         offset = rb_req.addr - `RB_BASE;
         case (offset)
            8'd0: begin
               rb_expect    = old_time[63:32];
               m_shadow_now = old_time;
            end
            8'd1: rb_expect = m_shadow_now[31:0];
            8'd2: begin
               rb_expect    = old_lastpps[63:32];
               m_shadow_pps = old_lastpps;
            end
            8'd3: rb_expect = m_shadow_pps[31:0];
            default: rb_expect = 32'd0; // Outside the readback window.
         endcase
      end
      @(negedge clk);
      check_value("vita_time", m_time, vita_time);
      check_value("vita_time_lastpps", m_lastpps, vita_time_lastpps);
      check_value("rb_resp.valid", {63'd0, stb_hist[`RB_LATENCY-1]},
                  {63'd0, rb_resp.valid}); // Valid only right after a strobe.
      set_bus = '0; // Strobes last one cycle.
      rb_req  = '0;
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      set_bus.stb  = 1'b1;
      set_bus.addr = addr;
      set_bus.data = data;
      step();
   endtask

   // Issue one read, wait for valid and compare with the model and optionally the file.
   task automatic read_word(input logic [7:0] addr, input logic use_file,
                            input logic [31:0] file_expect);
      int cycles;
      rb_req.stb  = 1'b1;
      rb_req.addr = addr;
      step();
      cycles = 1;
      while (!rb_resp.valid) begin
         if (cycles >= RB_TIMEOUT) begin
            $display("The readback port never answered the read of address %h", addr);
            $display("Regression failed");
            $fatal(1);
         end
         step();
         cycles++;
      end
      check_value("rb_resp.data", {32'd0, rb_expect}, {32'd0, rb_resp.data});
      if (use_file) begin
         check_value("rb_resp.data", {32'd0, file_expect}, {32'd0, rb_resp.data});
      end
   endtask

   task automatic pulse_pps(input int high_cycles);
      pps = 1'b1;
      repeat (high_cycles) step();
      pps = 1'b0;
   endtask

   initial begin
      int          fd;
      int          n;
      int          gap;
      string       line;
      string       op;
      logic [63:0] a;
      logic [63:0] d;
      logic [63:0] e;
      clk          = 1'b0;
      reset        = 1'b1;
      pps          = 1'b0;
      set_bus      = '0;
      rb_req       = '0;
      m_time       = 64'd0;
      m_lastpps    = 64'd0;
      m_next       = 64'd0;
      m_ctrl       = 2'b00;
      m_armed      = 1'b0;
      arm_cnt      = 0;
      pps_cnt      = 0;
      m_pps_prev   = 1'b0;
      m_shadow_now = 64'd0;
      m_shadow_pps = 64'd0;
      rb_expect    = 32'd0;
      stb_hist     = 8'd0;
      rng_state    = 32'h8139_ec49;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      fd = $fopen("tests/time_patterns.txt", "r");
      if (fd == 0) begin
         $display("Could not open the pattern file tests/time_patterns.txt");
         $display("Regression failed");
         $fatal(1);
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n == 0 || line.len() == 0 || line[0] == "#") continue;
         n = $sscanf(line, "%s %h %h %h", op, a, d, e);
         if (n < 4) continue; // Blank line.
         if (op == "write") begin
            write_setting(a[7:0], d[31:0]);
         end else if (op == "read") begin
            read_word(a[7:0], d[0], e[31:0]);
         end else if (op == "pps") begin
            pulse_pps(int'(a));
         end else if (op == "idle") begin
            repeat (int'(a)) step();
         end else if (op == "checktime") begin
            check_value("vita_time_lastpps", e, vita_time_lastpps);
         end else begin
            $display("Unknown operation in the pattern file: %s", op);
            $display("Regression failed");
            $fatal(1);
         end
         rng_state = xorshift_next(rng_state);
         gap = int'(rng_state % 32'd8); // Idle gap of 0 to 7 cycles.
         repeat (gap) step();
      end
      $fclose(fd);
      $display("Regression passed");
      $finish;
   end

endmodule

/* tests/time_patterns.txt */
# Columns (hex): op addr data expect. write: addr data. read: data 1 also checks expect.
# idle and pps: addr is a cycle count. checktime: expect is vita_time_lastpps.
read 10 0 0
read 11 0 0
idle 5 0 0
read 10 0 0
read 11 0 0
write 20 12345678 0
write 21 9abcdef0 0
write 22 1 0
idle 6 0 0
read 10 1 12345678
read 11 0 0
write 20 00000005 0
write 21 00000100 0
write 22 2 0
idle 14 0 0
read 10 0 0
pps 3 0 0
idle 8 0 0
checktime 0 0 0000000500000100
read 12 1 00000005
read 13 1 00000100
idle 10 0 0
pps 2 0 0
idle 18 0 0
pps 2 0 0
idle 8 0 0
read 12 0 0
read 13 0 0
write 20 00000001 0
write 21 fffffff8 0
write 22 1 0
idle 4 0 0
read 10 0 0
idle 12 0 0
read 11 0 0
read 10 1 00000002
read 30 1 00000000

/* files.f */
+incdir+include
rtl/time_pkg.sv
rtl/setting_reg.sv
rtl/timekeeper.sv
rtl/time_readback.sv
rtl/time_subsys_top.sv
tests/time_subsys_properties.sv
tests/time_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the time subsystem testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f files.f \
   --top-module time_subsys_tb \
   -o time_subsys_sim

./obj_dir/time_subsys_sim
